// File: tb.f
verilog/noc_pkg.sv
verilog/noc_buffer.sv
verilog/noc_demux.sv
verilog/noc_class_router.sv
tb/tb_clock.sv
tb/noc_router_checker.sv
tb/tb_noc_class_router.sv

// File: Bender.yml
# class-based flit router for one network-on-chip link.
package:
  name: noc_class_router

sources:
  # design, package first.
  - verilog/noc_pkg.sv
  - verilog/noc_buffer.sv
  - verilog/noc_demux.sv
  - verilog/noc_class_router.sv

  # testbench, top module tb_noc_class_router.
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/noc_router_checker.sv
      - tb/tb_noc_class_router.sv

// File: tb/tb_noc_class_router.sv
/*
 * Testbench top for the class router. Inputs change 1 ns after a rising edge.
 * Random classes, lengths, payloads and back-pressure come from one xorshift
 * generator. The stall test assumes class 1 maps to channel 1.
 */

`timescale 1ns/1ps

module tb_noc_class_router;

   localparam int n_multi_pkts   = 8;                          // fixed multi-flit packets.
   localparam int n_random_pkts  = 60;                         // random packets.
   localparam int stall_flits    = noc_pkg::in_buffer_depth + noc_pkg::out_buffer_depth + 1;
   localparam int total_flits    = 8 + n_multi_pkts * 4 + n_random_pkts * 4 + stall_flits;
   localparam int watchdog_cycles = total_flits * 40 + 200;    // bound on the whole run.

   logic                                                  clk;
   logic                                                  rst;
   logic [noc_pkg::flit_width-1:0]                        in_flit;
   logic                                                  in_valid;
   logic                                                  in_ready;
   logic [noc_pkg::channels-1:0][noc_pkg::flit_width-1:0] out_flit;
   logic [noc_pkg::channels-1:0]                          out_valid;
   logic [noc_pkg::channels-1:0]                          out_ready;
   logic        stall_check;                                   // both links held low.
   logic        drain_check;                                   // asks the checker for leftovers.
   logic        drain_done;
   logic        bp_random;                                     // random out_ready each cycle.
   int          value_errors;
   int          other_errors;
   int          flits_in;
   int          flits_out;
   logic [31:0] rng_state;

   tb_clock #(.period(100.0)) i_clock (.clk(clk));

   noc_class_router i_noc_class_router (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (out_flit),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   noc_router_checker i_checker (
      .clk          (clk),
      .rst          (rst),
      .in_flit      (in_flit),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .out_flit     (out_flit),
      .out_valid    (out_valid),
      .out_ready    (out_ready),
      .stall_check  (stall_check),
      .drain_check  (drain_check),
      .drain_done   (drain_done),
      .value_errors (value_errors),
      .other_errors (other_errors),
      .flits_in     (flits_in),
      .flits_out    (flits_out)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);                       // one shared stream.
      return rng_state;
   endfunction

   // new back-pressure pattern, each link ready about three cycles in four.
   task automatic shuffle_ready();
      logic [31:0] r;
      if (bp_random) begin
         r         = next_random();
         out_ready = r[noc_pkg::channels-1:0] | r[noc_pkg::channels+7:8];
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
         shuffle_ready();
      end
   endtask

   // offer one flit and hold it until the input takes it.
   task automatic send_flit(input logic [noc_pkg::flit_width-1:0] flit);
      logic taken;
      in_flit  = flit;
      in_valid = 1'b1;
      taken    = 1'b0;
      while (!taken) begin
         @(posedge clk);
         taken = in_ready;                                     // value before the edge.
         #1;
         shuffle_ready();
      end
      in_valid = 1'b0;
   endtask

   task automatic send_packet(input logic [2:0] cls, input int len);
      noc_pkg::flit_word_t            word;
      logic [noc_pkg::flit_width-1:0] flit;
      for (int i = 0; i < len; i++) begin
         word.data = next_random();                            // random payload and header fields.
         if (i == 0) word.hdr.class_id = cls;
         flit                          = '0;
         flit[noc_pkg::flit_data_width-1:0] = word.data;
         flit[noc_pkg::flit_first_bit] = (i == 0);
         flit[noc_pkg::flit_last_bit]  = (i == len - 1);
         send_flit(flit);
      end
   endtask

   task automatic wait_drained();
      wait (flits_out == flits_in);                            // every routed flit has left.
      @(posedge clk);
      #1;
   endtask

   initial begin : stimulus
      logic [31:0] r;
      rng_state   = 32'h3e0a_2095;
      rst         = 1'b1;
      in_flit     = '0;
      in_valid    = 1'b0;
      out_ready   = '0;
      stall_check = 1'b0;
      drain_check = 1'b0;
      bp_random   = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;
      idle_cycles(3);                                          // checker looks at the idle outputs.
      out_ready = '1;
      for (int c = 0; c < 8; c++) begin
         send_packet(c[2:0], 1);                               // every class once.
      end
      for (int p = 0; p < n_multi_pkts; p++) begin
         send_packet(p[2:0], 2 + p % 3);                       // 2 to 4 flits, classes alternate.
      end
      bp_random = 1'b1;
      for (int p = 0; p < n_random_pkts; p++) begin
         r = next_random();
         send_packet(r[2:0], 1 + int'(r[5:4]));
         idle_cycles((r[9:8] == 2'b00) ? 2 : 0);               // an occasional gap.
      end
      bp_random = 1'b0;
      out_ready = '1;
      wait_drained();
      out_ready   = '0;                                        // both links blocked.
      stall_check = 1'b1;
      fork
         for (int i = 0; i < stall_flits; i++) begin
            send_packet(3'd1, 1);
         end
         begin
            repeat (40) @(posedge clk);
            #1;
            stall_check  = 1'b0;
            out_ready[1] = 1'b1;                               // channel 1 drains again.
         end
      join
      out_ready = '1;
      wait_drained();
      drain_check = 1'b1;
      wait (drain_done);
      $display("closing report: %0d flits in, %0d flits out, %0d value errors, %0d other errors",
               flits_in, flits_out, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, a transfer never completed", watchdog_cycles);
      $display("Test failed");
      $finish;
   end

endmodule

// File: tb/noc_router_checker.sv
/*
 * Scoreboard for the class router. It expects every packet to open with a
 * first flag and close with a last flag, and it supports one stall window.
 * Counters are read by the testbench top for the closing report.
 */

`timescale 1ns/1ps

module noc_router_checker (
   input  logic                                                  clk,
   input  logic                                                  rst,
   input  logic [noc_pkg::flit_width-1:0]                        in_flit,
   input  logic                                                  in_valid,
   input  logic                                                  in_ready,
   input  logic [noc_pkg::channels-1:0][noc_pkg::flit_width-1:0] out_flit,
   input  logic [noc_pkg::channels-1:0]                          out_valid,
   input  logic [noc_pkg::channels-1:0]                          out_ready,
   input  logic                                                  stall_check, // both links held.
   input  logic                                                  drain_check, // run is over.
   output logic                                                  drain_done,
   output int                                                    value_errors,
   output int                                                    other_errors,
   output int                                                    flits_in,
   output int                                                    flits_out
);

   // flits the router can hold when the routed channel never drains.
   localparam int stall_limit = noc_pkg::in_buffer_depth + noc_pkg::out_buffer_depth;

   logic [noc_pkg::flit_width-1:0] exp_q [noc_pkg::channels][$]; // expected flits per channel.
   logic [noc_pkg::channels-1:0]   pkt_open;                   // a packet is under way on a channel.
   int                             cur_channel;                // channel of the packet entering.
   int                             stall_count;                // input transfers in the stall window.
   logic                           rst_prev;
   logic                           stall_prev;

   // class c owns byte c of the mapping, byte 0 on top. the lowest set bit of
   // the byte names the channel and an empty byte means channel 0.
   function automatic int expected_channel(input logic [2:0] cls);
      logic [7:0] entry;
      int         ch;
      entry = noc_pkg::class_mapping[63 - 8 * int'(cls) -: 8];
      ch    = 0;
      for (int i = noc_pkg::channels - 1; i >= 0; i--) begin
         if (entry[i]) ch = i;
      end
      return ch;
   endfunction

   initial begin
      value_errors = 0;
      other_errors = 0;
      flits_in     = 0;
      flits_out    = 0;
      drain_done   = 1'b0;
      pkt_open     = '0;
      cur_channel  = 0;
      stall_count  = 0;
      rst_prev     = 1'b1;
      stall_prev   = 1'b0;
   end

   always @(posedge clk) begin : monitor
      logic [noc_pkg::flit_width-1:0] expected;
      noc_pkg::flit_word_t            word;
      // first edge after reset with an idle input.
      if (rst_prev && !rst && !in_valid) begin
         if (out_valid !== '0) begin
            value_errors++;
            $display("ERROR: out_valid expected 0x%h actual 0x%h", '0, out_valid);
         end
         if (in_ready !== 1'b1) begin
            value_errors++;
            $display("ERROR: in_ready expected 0x1 actual 0x%h", in_ready);
         end
      end
      rst_prev = rst;
      if (!rst) begin
         // outputs first, so a queue is never read in the edge that fills it.
         for (int ch = 0; ch < noc_pkg::channels; ch++) begin
            if (out_valid[ch] && out_ready[ch]) begin
               flits_out++;
               if (exp_q[ch].size() == 0) begin
                  other_errors++;
                  $display("channel %0d sent flit %h that was never routed to it, at %0t",
                           ch, out_flit[ch], $time);
               end else begin
                  expected = exp_q[ch].pop_front();
                  if (out_flit[ch] !== expected) begin
                     value_errors++;
                     $display("ERROR: out_flit[%0d] expected 0x%h actual 0x%h at %0t",
                              ch, expected, out_flit[ch], $time);
                  end
               end
               // packets on one channel never overlap.
               if (out_flit[ch][noc_pkg::flit_first_bit] && pkt_open[ch]) begin
                  other_errors++;
                  $display("channel %0d started a packet inside another one, at %0t", ch, $time);
               end else if (!out_flit[ch][noc_pkg::flit_first_bit] && !pkt_open[ch]) begin
                  other_errors++;
                  $display("channel %0d sent a flit outside any packet, at %0t", ch, $time);
               end
               pkt_open[ch] = !out_flit[ch][noc_pkg::flit_last_bit];
            end
         end
         if (in_valid && in_ready) begin
            if (in_flit[noc_pkg::flit_first_bit]) begin
               word.data   = in_flit[noc_pkg::flit_data_width-1:0];
               cur_channel = expected_channel(word.hdr.class_id); // header picks the channel.
            end
            exp_q[cur_channel].push_back(in_flit);             // later flits follow the header.
            flits_in++;
            if (stall_check) begin
               if (stall_count >= stall_limit) begin
                  other_errors++;
                  $display("input took a flit beyond the buffer space while stalled, at %0t",
                           $time);
               end
               stall_count++;
            end
         end
         if (stall_prev && !stall_check && stall_count != stall_limit) begin
            other_errors++;
            $display("input took %0d flits while stalled instead of %0d",
                     stall_count, stall_limit);
         end
         stall_prev = stall_check;
         if (drain_check && !drain_done) begin
            for (int ch = 0; ch < noc_pkg::channels; ch++) begin
               if (exp_q[ch].size() != 0) begin
                  other_errors++;
                  $display("channel %0d still owes %0d flits at the end of the run",
                           ch, exp_q[ch].size());
               end
            end
            drain_done = 1'b1;                                 // the top may now report.
         end
      end
   end

endmodule

// File: tb/tb_clock.sv
/*
 * Free-running testbench clock, starting low at time zero.
 */

`timescale 1ns/1ps

module tb_clock #(
   parameter real period = 100.0                               // clock period in ns.
) (
   output logic clk
);

   initial begin
      clk = 1'b0;                                              // first rising edge at period/2.
      forever begin
         #(period / 2.0) clk = ~clk;
      end
   end

endmodule

// File: verilog/noc_class_router.sv
/*
 * Class router for one link: input buffer, class demux, one buffer per channel.
 * The earliest output transfer is two edges after the input transfer.
 * A blocked channel fills back to the input, no flit is dropped.
 */

`timescale 1ns/1ps

module noc_class_router (
   input  logic                                                  clk,
   input  logic                                                  rst,

   // input link.
   input  logic [noc_pkg::flit_width-1:0]                        in_flit,
   input  logic                                                  in_valid,
   output logic                                                  in_ready,

   // one output link per channel.
   output logic [noc_pkg::channels-1:0][noc_pkg::flit_width-1:0] out_flit,
   output logic [noc_pkg::channels-1:0]                          out_valid,
   input  logic [noc_pkg::channels-1:0]                          out_ready
);

   // input buffer to demux.
   logic [noc_pkg::flit_width-1:0]                        buf_flit;
   logic                                                  buf_valid;
   logic                                                  buf_ready;

   // demux to the output buffers.
   logic [noc_pkg::channels-1:0][noc_pkg::flit_width-1:0] dmx_flit;
   logic [noc_pkg::channels-1:0]                          dmx_valid;
   logic [noc_pkg::channels-1:0]                          dmx_ready;

   noc_buffer #(
      .depth     (noc_pkg::in_buffer_depth)
   ) i_in_buffer (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (buf_flit),
      .out_valid (buf_valid),
      .out_ready (buf_ready)
   );

   noc_demux i_demux (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (buf_flit),
      .in_valid  (buf_valid),
      .in_ready  (buf_ready),
      .out_flit  (dmx_flit),
      .out_valid (dmx_valid),
      .out_ready (dmx_ready)
   );

   // one output buffer per channel, each decoupling its link from the demux.
   for (genvar ch = 0; ch < noc_pkg::channels; ch++) begin : g_out
      noc_buffer #(
         .depth     (noc_pkg::out_buffer_depth)
      ) i_out_buffer (
         .clk       (clk),
         .rst       (rst),
         .in_flit   (dmx_flit[ch]),
         .in_valid  (dmx_valid[ch]),
         .in_ready  (dmx_ready[ch]),
         .out_flit  (out_flit[ch]),
         .out_valid (out_valid[ch]),
         .out_ready (out_ready[ch])
      );
   end

endmodule

// File: verilog/noc_demux.sv
/*
 * Class demultiplexer, steering each packet from one link to one channel.
 * The channel is taken from the header class and held until the last flit,
 * so a blocked channel stalls the input for every class.
 */

`timescale 1ns/1ps

module noc_demux (
   input  logic                                                  clk,
   input  logic                                                  rst,

   input  logic [noc_pkg::flit_width-1:0]                        in_flit,
   input  logic                                                  in_valid,
   output logic                                                  in_ready,

   output logic [noc_pkg::channels-1:0][noc_pkg::flit_width-1:0] out_flit,
   output logic [noc_pkg::channels-1:0]                          out_valid,
   input  logic [noc_pkg::channels-1:0]                          out_ready
);

   noc_pkg::flit_word_t                                word;      // data word of the input flit.
   logic [noc_pkg::class_msb-noc_pkg::class_lsb:0]     pkt_class; // class of the current flit.
   logic [noc_pkg::channels-1:0]                       select;    // channel from the class.
   logic [noc_pkg::channels-1:0]                       active;    // channel of an open packet.
   logic [noc_pkg::channels-1:0]                       route;     // channel used this cycle.
   logic                                               is_first;
   logic                                               is_last;
   logic                                               xfer;      // input transfer.

   always_comb begin
      word.data = in_flit[noc_pkg::flit_data_width-1:0];       // fill through the payload view.
   end

   assign pkt_class = word.hdr.class_id;                       // read through the header view.
   assign is_first  = in_flit[noc_pkg::flit_first_bit];
   assign is_last   = in_flit[noc_pkg::flit_last_bit];

   // byte c of the mapping starts at bit 8*(7-c), its low bits are the mask.
   always_comb begin
      select = noc_pkg::class_mapping[(7 - int'(pkt_class)) * 8 +: noc_pkg::channels];
      if (select == '0) begin
         select = noc_pkg::channels'(1);                       // unmapped class, use channel 0.
      end
   end

   assign route     = (active != '0) ? active : select;        // an open packet keeps its channel.
   assign out_flit  = {noc_pkg::channels{in_flit}};            // every channel sees the flit.
   assign out_valid = route & {noc_pkg::channels{in_valid}};   // only the routed one gets valid.
   assign in_ready  = |(route & out_ready);                    // ready of the routed channel.
   assign xfer      = in_valid & in_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         active <= '0;                                         // no packet open after reset.
      end else if (xfer && is_last) begin
         active <= '0;                                         // the packet is done.
      end else if (xfer && is_first && active == '0) begin
         active <= select;                                     // lock the channel for the packet.
      end
   end

   // every class maps to exactly one channel, there is no multicast.
   assert property (@(posedge clk) disable iff (rst)
      in_valid |-> $onehot(select))
      else $error("noc_demux: class %0d maps to mask %b", pkt_class, select);

   // the lock holds one channel at most, across the packet.
   assert property (@(posedge clk) disable iff (rst)
      $onehot0(active))
      else $error("noc_demux: active mask %b not one-hot", active);

   // a flit is offered on one channel only.
   assert property (@(posedge clk) disable iff (rst)
      $onehot0(out_valid))
      else $error("noc_demux: out_valid %b on several channels", out_valid);

endmodule

// File: verilog/noc_buffer.sv
/*
 * First-word-fall-through flit FIFO with valid/ready on both sides.
 * A written flit can leave one edge later at the earliest.
 * in_ready is high when not full, or when full and the head leaves this cycle.
 */

`timescale 1ns/1ps

module noc_buffer #(
   parameter int depth = 4                                     // number of flit entries.
) (
   input  logic                           clk,
   input  logic                           rst,

   input  logic [noc_pkg::flit_width-1:0] in_flit,             // flit from the upstream link.
   input  logic                           in_valid,
   output logic                           in_ready,

   output logic [noc_pkg::flit_width-1:0] out_flit,            // head of the buffer.
   output logic                           out_valid,
   input  logic                           out_ready
);

   localparam int ptr_width   = (depth > 1) ? $clog2(depth) : 1; // pointer bits.
   localparam int count_width = $clog2(depth + 1);             // occupancy counter bits.

   logic [noc_pkg::flit_width-1:0] mem [depth];                // flit storage.
   logic [ptr_width-1:0]           wr_ptr;                     // next entry to write.
   logic [ptr_width-1:0]           rd_ptr;                     // entry shown at the output.
   logic [count_width-1:0]         count;                      // flits held.
   logic                           full;
   logic                           wr_en;                      // upstream transfer.
   logic                           rd_en;                      // downstream transfer.

   assign full      = (count == count_width'(depth));          // no free entry left.
   assign out_valid = (count != '0);                           // head is valid when not empty.
   assign out_flit  = mem[rd_ptr];                             // fall-through read.
   assign in_ready  = ~full | out_ready;                       // a full buffer takes a flit on a read.

   assign wr_en = in_valid & in_ready;
   assign rd_en = out_valid & out_ready;

   // the tail entry takes the incoming flit.
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= in_flit;                               // store at the tail.
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;                                         // empty after reset.
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            // wrap by compare so that any depth works.
            wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;                    // a write alone adds a flit.
            2'b01:   count <= count - 1'b1;                    // a read alone removes a flit.
            default: count <= count;                           // no change for neither or both.
         endcase
      end
   end

   // the occupancy never passes the number of entries.
   assert property (@(posedge clk) disable iff (rst)
      count <= count_width'(depth))
      else $error("noc_buffer: count %0d above depth %0d", count, depth);

   // a stalled head keeps its flit until the downstream side takes it.
   assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_flit))
      else $error("noc_buffer: head flit changed while stalled");

endmodule

// File: verilog/noc_pkg.sv
/*
 * Shared flit layout, channel mapping and buffer depths of the class router.
 * The class field needs 8 bytes in class_mapping, so classes are 3 bits wide.
 * A zero mapping byte routes that class to channel 0.
 */

package noc_pkg;

   // flit layout, the two type flags sit above the payload.
   localparam int flit_data_width = 32;                        // payload bits of a flit.
   localparam int flit_type_width = 2;                         // first and last flags.
   localparam int flit_width      = flit_data_width + flit_type_width; // full flit, 34 bits.

   localparam int flit_last_bit   = flit_data_width;           // bit 32 closes a packet.
   localparam int flit_first_bit  = flit_data_width + 1;       // bit 33 opens a packet.

   // output links and the class field inside a header word.
   localparam int channels        = 2;                         // number of output links.
   localparam int class_msb       = 26;                        // top bit of the class field.
   localparam int class_lsb       = 24;                        // bottom bit of the class field.

   // one byte per class, byte 0 in bits 63:56. the low bits of a byte are a
   // one-hot channel mask, so class 0 goes to channel 0 and classes 1 and 2
   // go to channel 1; the empty bytes of classes 3 to 7 fall back to channel 0.
   localparam logic [63:0] class_mapping = {
      8'h01,                                                   // class 0 to channel 0.
      8'h02,                                                   // class 1 to channel 1.
      8'h02,                                                   // class 2 to channel 1.
      8'h00,                                                   // class 3 unmapped.
      8'h00,                                                   // class 4 unmapped.
      8'h00,                                                   // class 5 unmapped.
      8'h00,                                                   // class 6 unmapped.
      8'h00                                                    // class 7 unmapped.
   };

   // buffer depths in flits.
   localparam int in_buffer_depth  = 4;                        // shared input buffer.
   localparam int out_buffer_depth = 2;                        // each output buffer.

   // the data word of a flit, seen as a header or as plain payload.
   typedef union packed {
      struct packed {
         logic [4:0]                   dest;                   // destination node, bits 31:27.
         logic [class_msb-class_lsb:0] class_id;               // packet class, bits 26:24.
         logic [4:0]                   src;                    // source node, bits 23:19.
         logic [class_lsb-6:0]         reserved;               // unused, bits 18:0.
      } hdr;
      logic [flit_data_width-1:0] data;                        // plain payload view.
   } flit_word_t;

endpackage
